// File: verilog.f
+incdir+verilog
verilog/overworld_pkg.sv
verilog/tile_memory.sv
verilog/overworld_controller.sv
verilog/camera_mover.sv
verilog/pixel_renderer.sv
verilog/overworld_top.sv
verif/overworld_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module overworld_tb -f verilog.f -o simv
out=$(./obj_dir/simv)
echo "$out"
if echo "$out" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// File: verif/overworld_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "overworld_consts.svh"

module overworld_tb;

	localparam int CLK_PERIOD = 4;
	localparam int TICK_CYCLES = 8;
	localparam int RANDOM_TICKS = 200;
	localparam int WALK_STEPS = 110;
	localparam int MAP_DEPTH = `MAP_COLS * `MAP_ROWS;
	localparam int SPRITE_DEPTH = `SHEET_W * `SPRITE_SIZE;
	localparam int LOAD_CYCLES = 3 * MAP_DEPTH + SPRITE_DEPTH + 32;
	localparam int TOTAL_TICKS = 10 + RANDOM_TICKS + 4 * WALK_STEPS;
	localparam int WATCHDOG_CYCLES = 2 * (LOAD_CYCLES + TOTAL_TICKS * TICK_CYCLES + 3000);

	logic Clk;
	logic rstN;
	logic frameTick;
	logic [7:0] keycode;
	logic moving;
	overworld_pkg::direction_t direction;
	overworld_pkg::memLoad_t load;
	overworld_pkg::drawPos_t pixel;
	overworld_pkg::rgb_t rgb;

	integer seed = 4;
	int checkCount = 0;
	int errorCount = 0;
	int testChecks0;
	int testErrors0;

	// Mirrors of the loaded memories
	logic [3:0] mapMirror [MAP_DEPTH];
	logic [3:0] collideMirror [MAP_DEPTH];
	logic [3:0] spriteMirror [SPRITE_DEPTH];
	logic [23:0] palMirror [32];

	// Reference model state
	overworld_pkg::gameState_t mState = overworld_pkg::START;
	overworld_pkg::direction_t mFacing = overworld_pkg::DOWN;
	overworld_pkg::walkFrame_t mFrame = overworld_pkg::REST1;
	int mCount = 0;
	int mCamX = 0;
	int mCamY = 0;

	// Expected colours follow the 2-cycle pixel pipeline
	logic expValid0, expValid1, expValid2;
	overworld_pkg::rgb_t expColor0, expColor1, expColor2;

	overworld_top UUT (.Clk, .rstN, .frameTick, .keycode, .moving, .direction, .load, .pixel, .rgb);

	initial begin
		Clk = 1'b0;
		forever #(CLK_PERIOD / 2) Clk = ~Clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic checkEqual(input logic [23:0] got, input logic [23:0] exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Error at %0t ns: %s was %06h, expected %06h", $time, what, got, exp);
		end
	endtask

	always @(posedge Clk) begin
		expValid1 <= expValid0;
		expValid2 <= expValid1;
		expColor1 <= expColor0;
		expColor2 <= expColor1;
	end

	always @(negedge Clk) begin
		if (expValid2) checkEqual(rgb, expColor2, "pixel colour");
	end

	function automatic int randBelow(input int n);
		return int'($unsigned($random(seed)) % $unsigned(n));
	endfunction

	function automatic overworld_pkg::rgb_t pixelColor(input overworld_pkg::drawPos_t p);
		int x;
		int y;
		int sheetCol;
		int sIdx;
		int pIdx;
		x = int'(p.drawX);
		y = int'(p.drawY);
		if (!p.visible || mState != overworld_pkg::OVERWORLD) return '0;
		pIdx = mapMirror[((mCamY + y) >> `CELL_SHIFT) * `MAP_COLS + ((mCamX + x) >> `CELL_SHIFT)];
		if (x >= `CHAR_X && x < `CHAR_X + `SPRITE_SIZE && y >= `CHAR_Y
				&& y < `CHAR_Y + `SPRITE_SIZE) begin
			case (mFacing)
				overworld_pkg::DOWN: sheetCol = 0;
				overworld_pkg::LEFT: sheetCol = 3;
				overworld_pkg::UP: sheetCol = 6;
				default: sheetCol = 9;
			endcase
			if (mFrame == overworld_pkg::M2) sheetCol += 2;
			else if (mFrame != overworld_pkg::M1) sheetCol += 1;
			sIdx = spriteMirror[(y - `CHAR_Y) * `SHEET_W + sheetCol * `SPRITE_SIZE + x - `CHAR_X];
			if (sIdx != 0) pIdx = `SPRITE_PAL_BASE + sIdx;
		end
		return palMirror[pIdx];
	endfunction

	function automatic overworld_pkg::drawPos_t randomPixel(input int windowShare, input logic vis);
		overworld_pkg::drawPos_t p;
		if (randBelow(100) < windowShare) begin
			p.drawX = overworld_pkg::coord_t'(`CHAR_X + randBelow(`SPRITE_SIZE));
			p.drawY = overworld_pkg::coord_t'(`CHAR_Y + randBelow(`SPRITE_SIZE));
		end else begin
			p.drawX = overworld_pkg::coord_t'(randBelow(`SCREEN_W));
			p.drawY = overworld_pkg::coord_t'(randBelow(`SCREEN_H));
		end
		p.visible = vis;
		return p;
	endfunction

	task automatic renderPixels(input int n, input int windowShare, input logic vis);
		overworld_pkg::drawPos_t p;
		for (int i = 0; i < n; i++) begin
			@(posedge Clk);
			p = randomPixel(windowShare, vis);
			pixel <= p;
			expColor0 <= pixelColor(p);
			expValid0 <= 1'b1;
		end
		@(posedge Clk);
		expValid0 <= 1'b0;
		repeat (3) @(posedge Clk);
	endtask

	// One camera step under the collision and bounds rules
	task automatic moveCamera();
		logic [3:0] c;
		c = collideMirror[((mCamY + `CHAR_Y) >> `CELL_SHIFT) * `MAP_COLS
			+ ((mCamX + `CHAR_X) >> `CELL_SHIFT)];
		case (mFacing)
			overworld_pkg::UP: if (!c[3] && mCamY > 0) mCamY--;
			overworld_pkg::LEFT: if (!c[2] && mCamX > 0) mCamX--;
			overworld_pkg::DOWN: if (!c[1] && mCamY < `CAM_Y_MAX) mCamY++;
			default: if (!c[0] && mCamX < `CAM_X_MAX) mCamX++;
		endcase
	endtask

	task automatic modelTick(input logic [7:0] kc, input logic mv, input overworld_pkg::direction_t dir);
		if (mState == overworld_pkg::START) begin
			if (kc == `START_KEY) begin
				mState = overworld_pkg::OVERWORLD;
				mFacing = overworld_pkg::DOWN;
				mFrame = overworld_pkg::REST1;
				mCamX = `SPAWN_X;
				mCamY = `SPAWN_Y;
			end
		end else if (!mv) begin
			mFrame = overworld_pkg::REST1;
		end else if (dir != mFacing) begin
			mFacing = dir;
			mFrame = overworld_pkg::REST1;
		end else begin
			if (mCount == 0) mFrame = overworld_pkg::walkFrame_t'((int'(mFrame) + 1) % 4);
			mCount = (mCount + 1) % `STEP_DIV;
			moveCamera();
		end
	endtask

	task automatic tick(input logic [7:0] kc, input logic mv, input overworld_pkg::direction_t dir);
		@(posedge Clk);
		frameTick <= 1'b1;
		keycode <= kc;
		moving <= mv;
		direction <= dir;
		@(posedge Clk);
		frameTick <= 1'b0;
		// Step pulse, camera move, then the collision read settles
		repeat (TICK_CYCLES - 2) @(posedge Clk);
		modelTick(kc, mv, dir);
	endtask

	task automatic loadWord(input overworld_pkg::memRegion_t region, input int addr,
			input logic [23:0] data);
		@(posedge Clk);
		load <= '{region: region, addr: 12'(addr), data: data, we: 1'b1};
		case (region)
			overworld_pkg::MAP: mapMirror[addr] = data[3:0];
			overworld_pkg::COLLIDE: collideMirror[addr] = data[3:0];
			overworld_pkg::SPRITE: spriteMirror[addr] = data[3:0];
			default: palMirror[addr] = data;
		endcase
	endtask

	task automatic walk(input overworld_pkg::direction_t dir, input int steps);
		for (int i = 0; i < steps; i++) begin
			tick(8'h00, 1'b1, dir);
			if (i % 10 == 9) renderPixels(6, 30, 1'b1);
		end
	endtask

	task automatic startTest();
		testChecks0 = checkCount;
		testErrors0 = errorCount;
	endtask

	task automatic finishTest(input int num, input string name);
		$display("Test %0d %s: %0d checks, %0d errors", num, name, checkCount - testChecks0,
			errorCount - testErrors0);
	endtask

	initial begin
		logic [7:0] kc;
		rstN = 1'b0;
		frameTick = 1'b0;
		keycode = 8'h00;
		moving = 1'b0;
		direction = overworld_pkg::UP;
		load = '0;
		pixel = '0;
		expValid0 = 1'b0;
		expValid1 = 1'b0;
		expValid2 = 1'b0;
		expColor0 = '0;
		repeat (4) @(posedge Clk);
		rstN <= 1'b1;

		// Filled memories so the start screen has colours it must hide
		for (int a = 0; a < MAP_DEPTH; a++) loadWord(overworld_pkg::MAP, a, 24'(randBelow(16)));
		for (int a = 0; a < MAP_DEPTH; a++) begin
			loadWord(overworld_pkg::COLLIDE, a, randBelow(4) == 0 ? 24'(randBelow(16)) : 24'd0);
		end
		for (int a = 0; a < SPRITE_DEPTH; a++) begin
			loadWord(overworld_pkg::SPRITE, a, randBelow(4) == 0 ? 24'd0 : 24'(randBelow(16)));
		end
		for (int a = 0; a < 32; a++) loadWord(overworld_pkg::PALETTE, a, 24'($random(seed)));
		@(posedge Clk);
		load <= '0;

		startTest();
		renderPixels(10, 20, 1'b1);
		for (int i = 0; i < 5; i++) begin
			kc = 8'(randBelow(256));
			if (kc == `START_KEY) kc = kc + 8'h01;
			tick(kc, 1'b1, overworld_pkg::direction_t'(randBelow(4)));
		end
		renderPixels(10, 20, 1'b1);
		finishTest(1, "start screen black");

		startTest();
		tick(`START_KEY, 1'b0, overworld_pkg::DOWN);
		renderPixels(64, 0, 1'b1);
		finishTest(2, "spawn map colours");

		startTest();
		for (int i = 0; i < RANDOM_TICKS; i++) begin
			tick(8'h00, randBelow(4) != 0,
				randBelow(10) < 7 ? mFacing : overworld_pkg::direction_t'(randBelow(4)));
			renderPixels(6, 50, 1'b1);
		end
		finishTest(3, "random walking");

		startTest();
		for (int a = 0; a < MAP_DEPTH; a++) loadWord(overworld_pkg::COLLIDE, a, 24'd0);
		@(posedge Clk);
		load <= '0;
		walk(overworld_pkg::RIGHT, WALK_STEPS);
		walk(overworld_pkg::DOWN, WALK_STEPS);
		walk(overworld_pkg::LEFT, WALK_STEPS);
		walk(overworld_pkg::UP, WALK_STEPS);
		finishTest(4, "camera bounds");

		startTest();
		renderPixels(30, 30, 1'b0);
		finishTest(5, "hidden pixels black");

		$display("Summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/overworld_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "overworld_consts.svh"

module overworld_top (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic [7:0] keycode,
	input logic moving,
	input overworld_pkg::direction_t direction,
	input overworld_pkg::memLoad_t load,
	input overworld_pkg::drawPos_t pixel,
	output overworld_pkg::rgb_t rgb
);

	overworld_pkg::gameState_t gameState;
	overworld_pkg::direction_t facing;
	overworld_pkg::walkFrame_t frame;
	logic stepReq;
	logic spawn;
	overworld_pkg::camPos_t cam;
	overworld_pkg::mapAddr_t collideAddr;
	overworld_pkg::collide_t collide;
	overworld_pkg::mapAddr_t mapAddr;
	overworld_pkg::colorIdx_t mapIdx;
	overworld_pkg::spriteAddr_t spriteAddr;
	overworld_pkg::colorIdx_t spriteIdx;
	overworld_pkg::palIdx_t palAddr;
	overworld_pkg::rgb_t palColor;

	overworld_controller controller (.Clk, .rstN, .frameTick, .keycode, .moving, .direction,
		.gameState, .facing, .frame, .stepReq, .spawn);

	camera_mover mover (.Clk, .rstN, .stepReq, .spawn, .facing, .collideAddr, .collide, .cam);

	pixel_renderer renderer (.Clk, .rstN, .pixel, .cam, .gameState, .facing, .frame,
		.mapAddr, .mapIdx, .spriteAddr, .spriteIdx, .palAddr, .palColor, .rgb);

	tile_memory #(.REGION(overworld_pkg::MAP), .DEPTH(`MAP_COLS * `MAP_ROWS),
		.WIDTH($bits(overworld_pkg::colorIdx_t)))
		mapMem (.Clk, .load, .addr(mapAddr), .data(mapIdx));

	tile_memory #(.REGION(overworld_pkg::COLLIDE), .DEPTH(`MAP_COLS * `MAP_ROWS),
		.WIDTH($bits(overworld_pkg::collide_t)))
		collideMem (.Clk, .load, .addr(collideAddr), .data(collide));

	tile_memory #(.REGION(overworld_pkg::SPRITE), .DEPTH(`SHEET_W * `SPRITE_SIZE),
		.WIDTH($bits(overworld_pkg::colorIdx_t)))
		spriteMem (.Clk, .load, .addr(spriteAddr), .data(spriteIdx));

	tile_memory #(.REGION(overworld_pkg::PALETTE), .DEPTH(1 << $bits(overworld_pkg::palIdx_t)),
		.WIDTH($bits(overworld_pkg::rgb_t)))
		palMem (.Clk, .load, .addr(palAddr), .data(palColor));

endmodule

`default_nettype wire

// File: verilog/pixel_renderer.sv
`timescale 1ns/1ps
`default_nettype none

`include "overworld_consts.svh"

module pixel_renderer (
	input logic Clk,
	input logic rstN,
	input overworld_pkg::drawPos_t pixel,
	input overworld_pkg::camPos_t cam,
	input overworld_pkg::gameState_t gameState,
	input overworld_pkg::direction_t facing,
	input overworld_pkg::walkFrame_t frame,
	output overworld_pkg::mapAddr_t mapAddr,
	input overworld_pkg::colorIdx_t mapIdx,
	output overworld_pkg::spriteAddr_t spriteAddr,
	input overworld_pkg::colorIdx_t spriteIdx,
	output overworld_pkg::palIdx_t palAddr,
	input overworld_pkg::rgb_t palColor,
	output overworld_pkg::rgb_t rgb
);

	overworld_pkg::coord_t worldX;
	overworld_pkg::coord_t worldY;
	overworld_pkg::coord_t spriteRow;
	overworld_pkg::coord_t spriteCol;
	logic [3:0] dirBase;
	logic [1:0] poseOffs;
	logic [3:0] frameCol;
	logic inWindow;
	logic show;
	logic inWindowQ;
	logic showQ;
	logic showQ2;

	assign worldX = cam.camX + pixel.drawX;
	assign worldY = cam.camY + pixel.drawY;
	assign mapAddr = overworld_pkg::mapAddr_t'(worldY >> `CELL_SHIFT)
		* overworld_pkg::mapAddr_t'(`MAP_COLS)
		+ overworld_pkg::mapAddr_t'(worldX >> `CELL_SHIFT);

	assign inWindow = pixel.drawX >= overworld_pkg::coord_t'(`CHAR_X)
		&& pixel.drawX < overworld_pkg::coord_t'(`CHAR_X + `SPRITE_SIZE)
		&& pixel.drawY >= overworld_pkg::coord_t'(`CHAR_Y)
		&& pixel.drawY < overworld_pkg::coord_t'(`CHAR_Y + `SPRITE_SIZE);
	assign show = pixel.visible && (gameState == overworld_pkg::OVERWORLD);

	// Sheet columns come in groups of three per direction
	always_comb begin
		case (facing)
			overworld_pkg::DOWN: dirBase = 4'd0;
			overworld_pkg::LEFT: dirBase = 4'd3;
			overworld_pkg::UP: dirBase = 4'd6;
			default: dirBase = 4'd9;
		endcase
		case (frame)
			overworld_pkg::M1: poseOffs = 2'd0;
			overworld_pkg::M2: poseOffs = 2'd2;
			default: poseOffs = 2'd1;
		endcase
	end

	assign frameCol = dirBase + 4'(poseOffs);
	assign spriteRow = pixel.drawY - overworld_pkg::coord_t'(`CHAR_Y);
	assign spriteCol = pixel.drawX - overworld_pkg::coord_t'(`CHAR_X);
	assign spriteAddr = inWindow
		? overworld_pkg::spriteAddr_t'(spriteRow) * overworld_pkg::spriteAddr_t'(`SHEET_W)
			+ overworld_pkg::spriteAddr_t'(frameCol) * overworld_pkg::spriteAddr_t'(`SPRITE_SIZE)
			+ overworld_pkg::spriteAddr_t'(spriteCol)
		: '0;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			inWindowQ <= 1'b0;
			showQ <= 1'b0;
			showQ2 <= 1'b0;
		end else begin
			inWindowQ <= inWindow;
			showQ <= show;
			showQ2 <= showQ;
		end
	end

	// Index 0 in the sheet is transparent
	assign palAddr = (inWindowQ && spriteIdx != '0)
		? overworld_pkg::palIdx_t'(`SPRITE_PAL_BASE) + overworld_pkg::palIdx_t'(spriteIdx)
		: overworld_pkg::palIdx_t'(mapIdx);

	assign rgb = showQ2 ? palColor : '0;

endmodule

`default_nettype wire

// File: verilog/camera_mover.sv
`timescale 1ns/1ps
`default_nettype none

`include "overworld_consts.svh"

module camera_mover (
	input logic Clk,
	input logic rstN,
	input logic stepReq,
	input logic spawn,
	input overworld_pkg::direction_t facing,
	output overworld_pkg::mapAddr_t collideAddr,
	input overworld_pkg::collide_t collide,
	output overworld_pkg::camPos_t cam
);

	overworld_pkg::coord_t charWorldX;
	overworld_pkg::coord_t charWorldY;

	// Top-left world pixel under the sprite
	assign charWorldX = cam.camX + overworld_pkg::coord_t'(`CHAR_X);
	assign charWorldY = cam.camY + overworld_pkg::coord_t'(`CHAR_Y);

	always_ff @(posedge Clk) begin
		collideAddr <= overworld_pkg::mapAddr_t'(charWorldY >> `CELL_SHIFT)
			* overworld_pkg::mapAddr_t'(`MAP_COLS)
			+ overworld_pkg::mapAddr_t'(charWorldX >> `CELL_SHIFT);
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			cam <= '0;
		end else if (spawn) begin
			cam.camX <= overworld_pkg::coord_t'(`SPAWN_X);
			cam.camY <= overworld_pkg::coord_t'(`SPAWN_Y);
		end else if (stepReq) begin
			case (facing)
				overworld_pkg::UP:
					if (!collide[3] && cam.camY != '0) cam.camY <= cam.camY - 1'b1;
				overworld_pkg::LEFT:
					if (!collide[2] && cam.camX != '0) cam.camX <= cam.camX - 1'b1;
				overworld_pkg::DOWN:
					if (!collide[1] && cam.camY < overworld_pkg::coord_t'(`CAM_Y_MAX)) begin
						cam.camY <= cam.camY + 1'b1;
					end
				default:
					if (!collide[0] && cam.camX < overworld_pkg::coord_t'(`CAM_X_MAX)) begin
						cam.camX <= cam.camX + 1'b1;
					end
			endcase
		end
	end

	// Renderer relies on the screen never leaving the world
	camInBounds: assert property (@(posedge Clk) disable iff (!rstN)
		cam.camX <= overworld_pkg::coord_t'(`CAM_X_MAX)
		&& cam.camY <= overworld_pkg::coord_t'(`CAM_Y_MAX))
		else $error("camera out of bounds at %0d,%0d", cam.camX, cam.camY);

endmodule

`default_nettype wire

// File: verilog/overworld_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "overworld_consts.svh"

module overworld_controller (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic [7:0] keycode,
	input logic moving,
	input overworld_pkg::direction_t direction,
	output overworld_pkg::gameState_t gameState,
	output overworld_pkg::direction_t facing,
	output overworld_pkg::walkFrame_t frame,
	output logic stepReq,
	output logic spawn
);

	logic [$clog2(`STEP_DIV)-1:0] stepCount;

	function automatic overworld_pkg::walkFrame_t nextFrame(input overworld_pkg::walkFrame_t cur);
		overworld_pkg::walkFrame_t nxt;
		case (cur)
			overworld_pkg::REST1: nxt = overworld_pkg::M1;
			overworld_pkg::M1: nxt = overworld_pkg::REST2;
			overworld_pkg::REST2: nxt = overworld_pkg::M2;
			default: nxt = overworld_pkg::REST1;
		endcase
		return nxt;
	endfunction

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			gameState <= overworld_pkg::START;
			facing <= overworld_pkg::DOWN;
			frame <= overworld_pkg::REST1;
			stepCount <= '0;
			stepReq <= 1'b0;
			spawn <= 1'b0;
		end else begin
			// Strobes last one cycle
			stepReq <= 1'b0;
			spawn <= 1'b0;
			if (frameTick) begin
				case (gameState)
					overworld_pkg::START: begin
						if (keycode == `START_KEY) begin
							gameState <= overworld_pkg::OVERWORLD;
							facing <= overworld_pkg::DOWN;
							frame <= overworld_pkg::REST1;
							spawn <= 1'b1;
						end
					end
					overworld_pkg::OVERWORLD: begin
						if (!moving) begin
							frame <= overworld_pkg::REST1;
						end else if (direction != facing) begin
							// Turning in place costs one tick
							facing <= direction;
							frame <= overworld_pkg::REST1;
						end else begin
							stepReq <= 1'b1;
							if (stepCount == '0) begin
								frame <= nextFrame(frame);
							end
							// Counter keeps its phase across stops
							stepCount <= stepCount + 1'b1;
						end
					end
					default: gameState <= overworld_pkg::START;
				endcase
			end
		end
	end

	noStepInStart: assert property (@(posedge Clk) disable iff (!rstN)
		stepReq |-> (gameState == overworld_pkg::OVERWORLD))
		else $error("step request while on the start screen");

endmodule

`default_nettype wire

// File: verilog/tile_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tile_memory #(
	parameter overworld_pkg::memRegion_t REGION = overworld_pkg::MAP,
	parameter int DEPTH = 3072,
	parameter int WIDTH = 4
) (
	input logic Clk,
	input overworld_pkg::memLoad_t load,
	input logic [$clog2(DEPTH)-1:0] addr,
	output logic [WIDTH-1:0] data
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic hit;

	assign hit = load.we && (load.region == REGION);

	// Load port only answers its own region
	always_ff @(posedge Clk) begin
		if (hit) begin
			mem[load.addr[AW-1:0]] <= load.data[WIDTH-1:0];
		end
	end

	always_ff @(posedge Clk) begin
		data <= mem[addr];
	end

	// Loader must respect the size of each region
	loadInRange: assert property (@(posedge Clk) hit |-> (load.addr < DEPTH))
		else $error("load to region %0d at %0d past depth %0d", REGION, load.addr, DEPTH);

endmodule

`default_nettype wire

// File: verilog/overworld_pkg.sv
`default_nettype none

package overworld_pkg;

	typedef logic [9:0] coord_t;
	typedef logic [11:0] mapAddr_t;
	typedef logic [9:0] spriteAddr_t;
	typedef logic [4:0] palIdx_t;
	typedef logic [3:0] colorIdx_t;

	// Blocking bits: up, left, down, right from MSB
	typedef logic [3:0] collide_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// Matches the keypad direction encoding
	typedef enum logic [1:0] {UP = 2'd0, RIGHT = 2'd1, DOWN = 2'd2, LEFT = 2'd3} direction_t;

	typedef enum logic {START, OVERWORLD} gameState_t;

	typedef enum logic [1:0] {REST1, M1, REST2, M2} walkFrame_t;

	typedef struct packed {
		coord_t drawX;
		coord_t drawY;
		logic visible;
	} drawPos_t;

	typedef struct packed {
		coord_t camX;
		coord_t camY;
	} camPos_t;

	typedef enum logic [1:0] {MAP, COLLIDE, SPRITE, PALETTE} memRegion_t;

	typedef struct packed {
		memRegion_t region;
		logic [11:0] addr;
		logic [23:0] data;
		logic we;
	} memLoad_t;

endpackage

`default_nettype wire

// File: verilog/overworld_consts.svh
`ifndef OVERWORLD_CONSTS_SVH
`define OVERWORLD_CONSTS_SVH

// Visible screen in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// 4x4 pixel cells
`define CELL_SHIFT 2
`define MAP_COLS 64
`define MAP_ROWS 48

// Camera limits keep the screen inside the 256x192 world
`define CAM_X_MAX 96
`define CAM_Y_MAX 72
`define SPAWN_X 40
`define SPAWN_Y 40

// Fixed player window on screen
`define CHAR_X 76
`define CHAR_Y 56
`define SPRITE_SIZE 8

// Sheet holds 12 frames side by side
`define SHEET_W 96

`define STEP_DIV 8
`define START_KEY 8'h2C
`define SPRITE_PAL_BASE 16

`endif
